//--- list.f
verilog/memPkg.sv
verilog/memAccessDecode.sv
verilog/memByteArray.sv
verilog/memReadFormat.sv
verilog/memSubsystem.sv
tests/tbClock.sv
tests/memSubsystemTb.sv

//--- run.sh
#!/bin/sh
# Build and run the memory subsystem testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module memSubsystemTb -f list.f -o simv

out=$(./obj_dir/simv)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "All tests passed!"; then
	exit 0
fi
exit 1

//--- tests/memSubsystemTb.sv
`timescale 1ns/1ps

module memSubsystemTb;

	localparam int AddrWidth = 8;			// 256-byte array.
	localparam int Depth = 2 ** AddrWidth;
	localparam int Timeout = 20;			// Cycles allowed for any wait.
	localparam logic [1:0] SzHalf = 2'd1;
	localparam logic [1:0] SzWord = 2'd2;
	localparam logic [2:0] MsByteU = 3'b000;	// MS is {signed, size}.
	localparam logic [2:0] MsHalfU = 3'b001;
	localparam logic [2:0] MsWord = 3'b010;
	localparam logic [2:0] MsRsvd = 3'b011;
	localparam logic [2:0] MsByteS = 3'b100;
	localparam logic [2:0] MsHalfS = 3'b101;

	logic clk;
	logic arstN;
	logic MOV;
	logic ReadWrite;
	logic [2:0] MS;
	logic [31:0] DataIn;
	logic [31:0] Address;
	logic MOC;
	logic [31:0] DataOut;

	logic [7:0] refMem [Depth];			// Reference byte array.
	int errors = 0;
	int checks = 0;
	logic [31:0] rngState = 32'd2350;		// LCG state.

	tbClock clkGen (.clk(clk), .arstN(arstN));

	memSubsystem #(.AddrWidth(AddrWidth)) uut (
		.clk(clk), .arstN(arstN),
		.MOV(MOV), .ReadWrite(ReadWrite), .MS(MS),
		.DataIn(DataIn), .Address(Address),
		.MOC(MOC), .DataOut(DataOut)
	);

	function automatic logic [31:0] nextRandom();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	// Clears the low bits by size and drops the upper address bits.
	function automatic logic [AddrWidth-1:0] alignAddr(logic [1:0] size, logic [31:0] addr);
		logic [AddrWidth-1:0] a;
		a = addr[AddrWidth-1:0];
		if (size == SzHalf)
			a[0] = 1'b0;
		else if (size == SzWord)
			a[1:0] = 2'b00;
		return a;
	endfunction

	function automatic int byteCount(logic [1:0] size);
		return (size == 2'd0) ? 1 : (size == SzHalf) ? 2 : (size == SzWord) ? 4 : 0;
	endfunction

	// Big-endian store of the right-justified data.
	function automatic void modelWrite(logic [2:0] ms, logic [31:0] addr, logic [31:0] data);
		logic [AddrWidth-1:0] base;
		int n;
		base = alignAddr(ms[1:0], addr);
		n = byteCount(ms[1:0]);
		for (int k = 0; k < n; k++)
			refMem[base + AddrWidth'(k)] = data[8*(n-1-k) +: 8];
	endfunction

	function automatic logic [31:0] modelRead(logic [2:0] ms, logic [31:0] addr);
		logic [AddrWidth-1:0] base;
		logic [31:0] value;
		int n;
		base = alignAddr(ms[1:0], addr);
		n = byteCount(ms[1:0]);
		value = 32'd0;
		for (int k = 0; k < n; k++)
			value = {value[23:0], refMem[base + AddrWidth'(k)]};
		if (ms[2] && n < 4 && value[8*n-1])
			value = value | (32'hFFFF_FFFF << (8*n));	// Sign fill.
		return value;
	endfunction

	// Fill byte depends on every address bit.
	function automatic logic [31:0] fillWord(logic [31:0] addr);
		logic [31:0] value;
		value = 32'd0;
		for (int k = 0; k < 4; k++)
			value = {value[23:0], 8'(addr + 32'(k)) ^ 8'hA5};
		return value;
	endfunction

	task automatic compareValue(string name, logic [31:0] got, logic [31:0] exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("ERR %s got %08h expected %08h", name, got, exp);
		end
	endtask

	task automatic driveIdle();
		MOV = 1'b0;
		ReadWrite = 1'b0;
		MS = 3'b000;
		DataIn = 32'd0;
		Address = 32'd0;
	endtask

	task automatic waitMoc(output bit seen, output int cycles);
		seen = 1'b0;
		cycles = 1;				// Edge N already passed when MOV drops.
		while (!seen && cycles <= Timeout)
		begin
			@(negedge clk);
			cycles++;
			if (MOC)
				seen = 1'b1;
		end
	endtask

	// Issues one request and checks when its MOC arrives.
	task automatic access(bit rd, logic [2:0] ms, logic [31:0] addr, logic [31:0] data,
		output logic [31:0] result);
		bit seen;
		int cycles;
		@(negedge clk);
		MOV = 1'b1;
		ReadWrite = rd;
		MS = ms;
		Address = addr;
		DataIn = data;
		@(negedge clk);
		driveIdle();
		waitMoc(seen, cycles);
		result = DataOut;
		if (!seen)
		begin
			errors++;
			$display("No MOC within %0d cycles for the request at address %08h", Timeout, addr);
		end
		else
			compareValue("MOC latency", 32'(cycles), 32'd3);
		@(negedge clk);
		compareValue("MOC", 32'(MOC), 32'd0);	// Strobe lasts one cycle.
		if (!rd)
			modelWrite(ms, addr, data);
	endtask

	task automatic writeAccess(logic [2:0] ms, logic [31:0] addr, logic [31:0] data);
		logic [31:0] unused;
		access(1'b0, ms, addr, data, unused);
	endtask

	task automatic readExpect(logic [2:0] ms, logic [31:0] addr, logic [31:0] exp);
		logic [31:0] result;
		access(1'b1, ms, addr, 32'd0, result);
		compareValue("DataOut", result, exp);
	endtask

	task automatic readCheck(logic [2:0] ms, logic [31:0] addr);
		readExpect(ms, addr, modelRead(ms, addr));
	endtask

	task automatic resetState();
		int c;
		int pulses;
		for (c = 0; c < 40 && arstN !== 1'b1; c++)
			@(posedge clk);
		if (arstN !== 1'b1)
		begin
			errors++;
			$display("Reset was never released");
		end
		@(negedge clk);
		compareValue("MOC", 32'(MOC), 32'd0);
		compareValue("DataOut", DataOut, 32'd0);
		pulses = 0;
		repeat (8)
		begin
			@(negedge clk);
			if (MOC)
				pulses++;
		end
		compareValue("MOC pulses while idle", 32'(pulses), 32'd0);
	endtask

	// Issues one request per cycle and checks completions in issue order.
	task automatic runBurst(int count, bit fill);
		logic [31:0] expQ [$];
		bit readQ [$];
		logic [31:0] rnd;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] lastAddr;
		logic [31:0] exp;
		logic [2:0] ms;
		bit rd;
		bit wasRead;
		int issued;
		int done;
		int idle;
		issued = 0;
		done = 0;
		idle = 0;
		lastAddr = 32'd0;
		while (done < count && idle < Timeout)
		begin
			@(negedge clk);
			if (MOC)
			begin
				if (readQ.size() == 0)
				begin
					errors++;
					$display("MOC pulsed with no request pending");
				end
				else
				begin
					wasRead = readQ.pop_front();
					exp = expQ.pop_front();
					if (wasRead)
						compareValue("DataOut", DataOut, exp);
				end
				done++;
			end
			if (issued < count)
			begin
				rnd = nextRandom();
				if (fill)
				begin
					rd = 1'b0;
					ms = MsWord;
					addr = 32'(issued * 4);
					data = fillWord(addr);
				end
				else
				begin
					rd = issued[0] ? 1'b1 : rnd[20];	// Odd slots read the previous address.
					ms = {rnd[4], (rnd[9:8] == 2'd3) ? SzWord : rnd[9:8]};
					addr = issued[0] ? lastAddr : nextRandom();
					data = nextRandom();
				end
				if (rd)
					expQ.push_back(modelRead(ms, addr));
				else
				begin
					modelWrite(ms, addr, data);
					expQ.push_back(32'd0);
				end
				readQ.push_back(rd);
				lastAddr = addr;
				MOV = 1'b1;
				ReadWrite = rd;
				MS = ms;
				Address = addr;
				DataIn = data;
				issued++;
			end
			else
			begin
				driveIdle();
				idle++;
			end
		end
		driveIdle();
		compareValue("MOC count", 32'(done), 32'(count));
	endtask

	task automatic wordAccess();
		logic [31:0] addr;
		logic [31:0] data;
		addr = nextRandom() & 32'hFFFF_FFFC;
		data = nextRandom();
		writeAccess(MsWord, addr, data);
		readExpect(MsWord, addr, data);
		for (int k = 0; k < 4; k++)
			readExpect(MsByteU, addr + 32'(k), {24'd0, data[31-8*k -: 8]});
	endtask

	task automatic narrowReads();
		writeAccess(MsWord, 32'h40, 32'h7F80_1234);
		readExpect(MsByteU, 32'h40, 32'h0000_007F);
		readExpect(MsByteS, 32'h40, 32'h0000_007F);	// Top bit clear.
		readExpect(MsByteU, 32'h41, 32'h0000_0080);
		readExpect(MsByteS, 32'h41, 32'hFFFF_FF80);	// Top bit set.
		readExpect(MsHalfS, 32'h40, 32'h0000_7F80);
		readExpect(MsHalfU, 32'h42, 32'h0000_1234);
		writeAccess(MsHalfU, 32'h42, 32'h0000_8001);
		readExpect(MsHalfS, 32'h42, 32'hFFFF_8001);
		readExpect(MsHalfU, 32'h42, 32'h0000_8001);
		readExpect(MsByteS, 32'h43, 32'h0000_0001);
	endtask

	task automatic alignment();
		logic [31:0] base;
		logic [31:0] data;
		base = nextRandom() & 32'hFFFF_FFFC;		// Upper bits exercise the wrap.
		data = nextRandom();
		writeAccess(MsWord, base | 32'd3, data);
		readExpect(MsWord, base, data);
		readExpect(MsWord, base | 32'd1, data);
		writeAccess(MsHalfU, base | 32'd1, 32'h0000_BEEF);
		readExpect(MsWord, base, {16'hBEEF, data[15:0]});
		writeAccess(MsByteU, base | 32'd3, 32'h0000_005C);
		readExpect(MsWord, base, {16'hBEEF, data[15:8], 8'h5C});
		readExpect(MsHalfU, base | 32'd3, {16'd0, data[15:8], 8'h5C});
		readCheck(MsWord, base + 32'd4);		// Neighbour word untouched.
	endtask

	task automatic reservedSize();
		logic [31:0] addr;
		bit seen;
		int cycles;
		addr = nextRandom() & 32'hFFFF_FFFC;
		@(negedge clk);
		MOV = 1'b1;
		ReadWrite = 1'b0;
		MS = MsRsvd;
		Address = addr;
		DataIn = 32'hDEAD_BEEF;
		@(negedge clk);
		driveIdle();
		waitMoc(seen, cycles);				// Expected to run out.
		if (seen)
		begin
			errors++;
			$display("MOC pulsed for a reserved size request");
		end
		readCheck(MsWord, addr);			// Model was not written.
	endtask

	initial
	begin
		driveIdle();
		resetState();
		runBurst(Depth / 4, 1'b1);			// Known contents everywhere.
		wordAccess();
		narrowReads();
		alignment();
		runBurst(64, 1'b0);
		reservedSize();
		$display("Summary: %0d errors in %0d checks", errors, checks);
		if (errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

//--- tests/tbClock.sv
`timescale 1ns/1ps

module tbClock #(
	parameter int HalfPeriod = 5,			// 10 ns clock period.
	parameter int ResetCycles = 16			// Cycles with arstN held low.
) (
	output logic clk,
	output logic arstN
);
	initial
	begin
		clk = 1'b0;
		forever #HalfPeriod clk = ~clk;
	end

	initial
	begin
		arstN = 1'b0;
		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;				// Released away from the active edge.
	end

endmodule

//--- verilog/memAccessDecode.sv
`timescale 1ns/1ps

module memAccessDecode #(
	parameter int AddrWidth = 8					// Depth is 2^AddrWidth bytes.
) (
	input logic clk,
	input logic arstN,
	input logic MOV,						// Request strobe.
	input logic ReadWrite,						// 1 = read, 0 = write.
	input logic [2:0] MS,						// Sign flag and access size.
	input logic [31:0] Address,					// Only the low bits address the array.
	input logic [memPkg::DataWidth-1:0] DataIn,			// Right-justified write data.
	output logic reqValid,						// Accepted request.
	output logic reqRead,						// Read flag of the request.
	output logic [AddrWidth-1:0] baseAddr,				// Aligned address.
	output logic [memPkg::LaneCount-1:0] laneWe,			// Per-lane write enables.
	output logic [memPkg::DataWidth-1:0] laneData,			// Write data placed in its lanes.
	output memPkg::accessSize reqSize,				// Size for the result stage.
	output logic reqSigned						// Sign flag for the result stage.
);
	import memPkg::*;

	accessSize inSize;						// Decoded size of the incoming request.
	logic inAccept;							// Request with a supported size.
	logic [AddrWidth-1:0] inAddr;					// Address folded into the array range.
	logic [AddrWidth-1:0] alignedAddr;				// Low bits cleared by size.
	logic [LaneCount-1:0] steerWe;					// Lane enables before registering.
	logic [DataWidth-1:0] steerData;				// Lane data before registering.

	assign inSize = accessSize'(MS[1:0]);
	assign inAccept = MOV && (inSize != AccRsvd);			// Reserved size is dropped here.
	assign inAddr = Address[AddrWidth-1:0];				// Addresses wrap.

	// Big-endian alignment and lane steering.
	always_comb
	begin
		alignedAddr = inAddr;
		steerWe = '0;
		steerData = '0;
		case (inSize)
			AccByte:
			begin
				steerWe[0] = 1'b1;				// Byte sits at baseAddr itself.
				steerData[DataWidth-1 -: ByteWidth] = DataIn[ByteWidth-1:0];
			end
			AccHalf:
			begin
				alignedAddr[0] = 1'b0;				// Even address.
				steerWe[1:0] = 2'b11;				// Lanes 0 and 1.
				steerData[DataWidth-1 -: HalfWidth] = DataIn[HalfWidth-1:0];
			end
			AccWord:
			begin
				alignedAddr[1:0] = 2'b00;			// Word boundary.
				steerWe = '1;					// All four lanes.
				steerData = DataIn;
			end
			default:
			begin
				steerWe = '0;					// Reserved size writes nothing.
			end
		endcase
		if (ReadWrite)
			steerWe = '0;					// Reads never write.
	end

	// Control state.
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			reqValid <= 1'b0;
			reqRead <= 1'b0;
			laneWe <= '0;
		end
		else
		begin
			reqValid <= inAccept;
			reqRead <= ReadWrite;
			laneWe <= inAccept ? steerWe : '0;		// Idle cycles write nothing.
		end
	end

	// Request payload.
	always_ff @(posedge clk)
	begin
		baseAddr <= alignedAddr;
		laneData <= steerData;
		reqSize <= inSize;
		reqSigned <= MS[2];					// Sign extension flag.
	end

	// An accepted request never carries the reserved size.
	rsvdDropped: assert property (@(posedge clk) disable iff (!arstN)
		reqValid |-> (reqSize != AccRsvd))
		else $error("reqValid raised for a reserved size");

endmodule

//--- verilog/memByteArray.sv
`timescale 1ns/1ps

module memByteArray #(
	parameter int AddrWidth = 8					// Byte address bits.
) (
	input logic clk,
	input logic arstN,
	input logic reqValid,						// Accepted request from decode.
	input logic reqRead,						// 1 = read.
	input logic [AddrWidth-1:0] baseAddr,				// Aligned start address.
	input logic [memPkg::LaneCount-1:0] laneWe,			// Lane i writes baseAddr+i.
	input logic [memPkg::DataWidth-1:0] laneData,			// Lane 0 in the top byte.
	input memPkg::accessSize reqSize,
	input logic reqSigned,
	output logic rdValid,						// Read finished, rawWord valid.
	output logic wrDone,						// Write finished.
	output logic [memPkg::DataWidth-1:0] rawWord,			// Bytes at baseAddr, MSB first.
	output memPkg::accessSize rdSize,
	output logic rdSigned
);
	import memPkg::*;

	localparam int Depth = 2 ** AddrWidth;				// Array depth in bytes.

	logic [ByteWidth-1:0] mem [Depth];				// The byte array.
	logic [AddrWidth-1:0] laneAddr [LaneCount];			// Address of each lane.

	// Lane addresses, wrapping at the top of the array.
	always_comb
	begin
		for (int i = 0; i < LaneCount; i++)
			laneAddr[i] = baseAddr + AddrWidth'(i);
	end

	// Array writes and raw reads.
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < LaneCount; i++)
		begin
			if (reqValid && laneWe[i])
				mem[laneAddr[i]] <= laneData[DataWidth-1-i*ByteWidth -: ByteWidth];
		end
		if (reqValid && reqRead)
		begin
			for (int i = 0; i < LaneCount; i++)
				rawWord[DataWidth-1-i*ByteWidth -: ByteWidth] <= mem[laneAddr[i]];
		end
		rdSize <= reqSize;					// Travels with the request.
		rdSigned <= reqSigned;
	end

	// Completion flags.
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			rdValid <= 1'b0;
			wrDone <= 1'b0;
		end
		else
		begin
			rdValid <= reqValid && reqRead;
			wrDone <= reqValid && !reqRead;
		end
	end

	// Decode must never steer write lanes for a read.
	noWriteOnRead: assert property (@(posedge clk) disable iff (!arstN)
		reqRead |-> (laneWe == '0))
		else $error("laneWe set during a read");

endmodule

//--- verilog/memPkg.sv
package memPkg;

	// Bus and lane geometry.
	localparam int DataWidth = 32;				// Width of the data bus.
	localparam int ByteWidth = 8;				// One byte lane.
	localparam int HalfWidth = 16;				// Two byte lanes.
	localparam int LaneCount = DataWidth / ByteWidth;	// Byte lanes per word, lane 0 is the MSB.

	// Access size, taken from the low two bits of MS.
	typedef enum logic [1:0] {
		AccByte = 2'd0,					// Single byte.
		AccHalf = 2'd1,					// Halfword, even address.
		AccWord = 2'd2,					// Word, address multiple of four.
		AccRsvd = 2'd3					// Unsupported, no access and no MOC.
	} accessSize;

endpackage

//--- verilog/memReadFormat.sv
`timescale 1ns/1ps

module memReadFormat (
	input logic clk,
	input logic arstN,
	input logic rdValid,						// Read completed in the array.
	input logic wrDone,						// Write completed in the array.
	input logic [memPkg::DataWidth-1:0] rawWord,			// Raw big-endian bytes.
	input memPkg::accessSize rdSize,
	input logic rdSigned,						// Sign-extend byte and halfword.
	output logic MOC,						// One-cycle completion strobe.
	output logic [memPkg::DataWidth-1:0] DataOut			// Right-justified read result.
);
	import memPkg::*;

	logic signBit;							// Fill bit for narrow reads.
	logic [DataWidth-1:0] fmtWord;					// Formatted read result.

	// Right-justify and extend, sign taken from the assembled value.
	always_comb
	begin
		signBit = rdSigned && rawWord[DataWidth-1];
		case (rdSize)
			AccByte:
				fmtWord = {{(DataWidth-ByteWidth){signBit}}, rawWord[DataWidth-1 -: ByteWidth]};
			AccHalf:
				fmtWord = {{(DataWidth-HalfWidth){signBit}}, rawWord[DataWidth-1 -: HalfWidth]};
			default:
				fmtWord = rawWord;				// Full word as is.
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			MOC <= 1'b0;
			DataOut <= '0;
		end
		else
		begin
			MOC <= rdValid || wrDone;			// Any completion.
			if (rdValid)
				DataOut <= fmtWord;			// Holds until the next read.
		end
	end

	// One request per cycle, so a read and a write never finish together.
	oneCompletion: assert property (@(posedge clk) disable iff (!arstN)
		!(rdValid && wrDone))
		else $error("rdValid and wrDone high together");

endmodule

//--- verilog/memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem #(
	parameter int AddrWidth = 8					// Depth is 2^AddrWidth bytes.
) (
	input logic clk,
	input logic arstN,
	input logic MOV,						// Request strobe.
	input logic ReadWrite,						// 1 = read.
	input logic [2:0] MS,						// Sign flag and size.
	input logic [memPkg::DataWidth-1:0] DataIn,
	input logic [31:0] Address,
	output logic MOC,						// Completion strobe.
	output logic [memPkg::DataWidth-1:0] DataOut
);
	import memPkg::*;

	// Decode to execute.
	logic reqValid;
	logic reqRead;
	logic [AddrWidth-1:0] baseAddr;
	logic [LaneCount-1:0] laneWe;
	logic [DataWidth-1:0] laneData;
	accessSize reqSize;
	logic reqSigned;

	// Execute to result.
	logic rdValid;
	logic wrDone;
	logic [DataWidth-1:0] rawWord;
	accessSize rdSize;
	logic rdSigned;

	memAccessDecode #(.AddrWidth(AddrWidth)) decode (
		.clk(clk), .arstN(arstN),
		.MOV(MOV), .ReadWrite(ReadWrite), .MS(MS),
		.Address(Address), .DataIn(DataIn),
		.reqValid(reqValid), .reqRead(reqRead), .baseAddr(baseAddr),
		.laneWe(laneWe), .laneData(laneData),
		.reqSize(reqSize), .reqSigned(reqSigned)
	);

	memByteArray #(.AddrWidth(AddrWidth)) execute (
		.clk(clk), .arstN(arstN),
		.reqValid(reqValid), .reqRead(reqRead), .baseAddr(baseAddr),
		.laneWe(laneWe), .laneData(laneData),
		.reqSize(reqSize), .reqSigned(reqSigned),
		.rdValid(rdValid), .wrDone(wrDone), .rawWord(rawWord),
		.rdSize(rdSize), .rdSigned(rdSigned)
	);

	memReadFormat result (
		.clk(clk), .arstN(arstN),
		.rdValid(rdValid), .wrDone(wrDone), .rawWord(rawWord),
		.rdSize(rdSize), .rdSigned(rdSigned),
		.MOC(MOC), .DataOut(DataOut)
	);

endmodule
